// ==== verilog/fpu_queue_pkg.sv ====
// ========================================
// FPU instruction queue shared types
// ========================================
`default_nettype none

package fpu_queue_pkg;

    // ========================================
    // Field types
    // ========================================

    // Escape opcode [7:5], ModR/M reg [4:2], ModR/M mod [1:0]
    typedef logic [7:0] instr_code_t;

    // ST(i) offset from TOP, or a physical register number
    typedef logic [2:0] stack_index_t;

    // Memory operand width code
    typedef logic [1:0] operand_size_t;

    // Extended precision operand
    typedef logic [79:0] fpu_data_t;

    // Queue occupancy, enough for the default depth
    typedef logic [1:0] queue_count_t;

    // Operand size encodings
    localparam operand_size_t OPSZ_16 = 2'd0;
    localparam operand_size_t OPSZ_32 = 2'd1;
    localparam operand_size_t OPSZ_64 = 2'd2;
    localparam operand_size_t OPSZ_80 = 2'd3;

    // ========================================
    // Configuration
    // ========================================
    localparam int DEFAULT_QUEUE_DEPTH = 3;

    // Execute cycles before the size term is added
    localparam int BASE_LATENCY = 2;

    // Sequencer FSM
    typedef enum logic {
        SEQ_IDLE,
        SEQ_EXEC
    } seq_state_t;

endpackage

`default_nettype wire

// ==== verilog/fpu_instr_decoder.sv ====
// ========================================
// Escape instruction decoder
// ========================================
`timescale 1ns/1ps
`default_nettype none

module fpu_instr_decoder (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        cmd_strobe,
    input  logic [2:0]                  cmd_esc,
    input  logic [7:0]                  cmd_modrm,
    input  fpu_queue_pkg::fpu_data_t    cmd_data,
    output logic                        enqueue,
    output fpu_queue_pkg::instr_code_t  instruction_out,
    output fpu_queue_pkg::stack_index_t stack_index_out,
    output logic                        has_memory_op_out,
    output fpu_queue_pkg::operand_size_t operand_size_out,
    output logic                        is_integer_out,
    output logic                        is_bcd_out,
    output fpu_queue_pkg::fpu_data_t    data_out
);

    // ModR/M fields
    logic [1:0] modrm_mod;
    logic [2:0] modrm_reg;
    logic [2:0] modrm_rm;

    // Decoded fields before the output register
    logic                          dec_memory;
    fpu_queue_pkg::operand_size_t  dec_size;
    logic                          dec_integer;
    logic                          dec_bcd;

    assign modrm_mod = cmd_modrm[7:6];
    assign modrm_reg = cmd_modrm[5:3];
    assign modrm_rm  = cmd_modrm[2:0];

    // mod == 3 selects a register operand
    assign dec_memory = (modrm_mod != 2'd3);

    always_comb begin
        // Register forms work on the 80-bit stack format
        dec_size    = fpu_queue_pkg::OPSZ_80;
        dec_integer = 1'b0;
        dec_bcd     = 1'b0;
        if (dec_memory) begin
            // Escape pairs share an operand type
            case (cmd_esc[2:1])
                2'd0: dec_size = fpu_queue_pkg::OPSZ_32;
                2'd1: begin
                    dec_size    = fpu_queue_pkg::OPSZ_32;
                    dec_integer = 1'b1;
                end
                2'd2: dec_size = fpu_queue_pkg::OPSZ_64;
                default: begin
                    dec_size    = fpu_queue_pkg::OPSZ_16;
                    dec_integer = 1'b1;
                end
            endcase
            // FBLD / FBSTP, packed BCD in ten bytes
            if (cmd_esc == 3'd7 && (modrm_reg == 3'd4 || modrm_reg == 3'd6)) begin
                dec_size    = fpu_queue_pkg::OPSZ_80;
                dec_integer = 1'b0;
                dec_bcd     = 1'b1;
            end
        end
    end

    // ========================================
    // Output register
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            enqueue <= 1'b0;
        end else begin
            enqueue <= cmd_strobe;
        end
    end

    // Payload follows the strobe, no reset needed
    always_ff @(posedge clk) begin
        if (cmd_strobe) begin
            instruction_out   <= {cmd_esc, modrm_reg, modrm_mod};
            stack_index_out   <= dec_memory ? 3'd0 : modrm_rm;
            has_memory_op_out <= dec_memory;
            operand_size_out  <= dec_size;
            is_integer_out    <= dec_integer;
            is_bcd_out        <= dec_bcd;
            data_out          <= cmd_data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fpu_instruction_queue.sv ====
// ========================================
// FPU instruction FIFO
// ========================================
`timescale 1ns/1ps
`default_nettype none

module fpu_instruction_queue #(
    parameter int QUEUE_DEPTH = 3
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          enqueue,
    input  fpu_queue_pkg::instr_code_t    instruction_in,
    input  fpu_queue_pkg::stack_index_t   stack_index_in,
    input  logic                          has_memory_op_in,
    input  fpu_queue_pkg::operand_size_t  operand_size_in,
    input  logic                          is_integer_in,
    input  logic                          is_bcd_in,
    input  fpu_queue_pkg::fpu_data_t      data_in,
    input  logic                          dequeue,
    input  logic                          flush_queue,
    output fpu_queue_pkg::instr_code_t    instruction_out,
    output fpu_queue_pkg::stack_index_t   stack_index_out,
    output logic                          has_memory_op_out,
    output fpu_queue_pkg::operand_size_t  operand_size_out,
    output logic                          is_integer_out,
    output logic                          is_bcd_out,
    output fpu_queue_pkg::fpu_data_t      data_out,
    output logic                          queue_full,
    output logic                          queue_empty,
    output fpu_queue_pkg::queue_count_t   queue_count,
    output logic                          overflow
);

    // Entry layout is instr, index, mem, size, int, bcd, data
    localparam int ENTRY_W = 8 + 3 + 1 + 2 + 1 + 1 + 80;
    localparam int PTR_W   = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    logic [ENTRY_W-1:0] storage [QUEUE_DEPTH];
    logic [ENTRY_W-1:0] entry_in;
    logic [ENTRY_W-1:0] head_entry;

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;

    logic push;
    logic pop;

    // Handshake qualified by status
    assign push = enqueue && !queue_full;
    assign pop  = dequeue && !queue_empty;

    assign queue_full  = (queue_count == fpu_queue_pkg::queue_count_t'(QUEUE_DEPTH));
    assign queue_empty = (queue_count == '0);

    assign entry_in = {instruction_in, stack_index_in, has_memory_op_in,
                       operand_size_in, is_integer_in, is_bcd_in, data_in};

    // Head is zeroed while nothing is stored
    assign head_entry = queue_empty ? '0 : storage[rd_ptr];

    assign {instruction_out, stack_index_out, has_memory_op_out,
            operand_size_out, is_integer_out, is_bcd_out, data_out} = head_entry;

    // ========================================
    // Pointers and count
    // ========================================
    always_ff @(posedge clk) begin
        if (reset || flush_queue) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            queue_count <= '0;
        end else begin
            if (push) begin
                // Wrap at depth, not at the pointer width
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                queue_count <= queue_count + 1'b1;
            end else if (pop && !push) begin
                queue_count <= queue_count - 1'b1;
            end
        end
    end

    // Dropped entry flagged one cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            overflow <= 1'b0;
        end else begin
            overflow <= enqueue && queue_full && !flush_queue;
        end
    end

    // ========================================
    // Storage write
    // ========================================
    always_ff @(posedge clk) begin
        if (push && !flush_queue) begin
            storage[wr_ptr] <= entry_in;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fpu_exec_sequencer.sv ====
// ========================================
// FPU execution sequencer
// ========================================
`timescale 1ns/1ps
`default_nettype none

module fpu_exec_sequencer (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush_queue,
    input  logic                          queue_empty,
    input  fpu_queue_pkg::instr_code_t    head_instruction,
    input  fpu_queue_pkg::stack_index_t   head_stack_index,
    input  logic                          head_has_memory_op,
    input  fpu_queue_pkg::operand_size_t  head_operand_size,
    input  fpu_queue_pkg::fpu_data_t      head_data,
    output logic                          dequeue,
    output logic                          done,
    output fpu_queue_pkg::instr_code_t    done_instruction,
    output fpu_queue_pkg::stack_index_t   done_phys_reg,
    output fpu_queue_pkg::fpu_data_t      done_data,
    output fpu_queue_pkg::stack_index_t   stack_top
);

    fpu_queue_pkg::seq_state_t state;

    // Remaining execute cycles, done registered on the last one
    logic [2:0] lat_count;
    logic [2:0] lat_start;

    // Entry in execution
    fpu_queue_pkg::instr_code_t  cur_instr;
    fpu_queue_pkg::stack_index_t cur_index;
    logic                        cur_memory;
    fpu_queue_pkg::fpu_data_t    cur_data;

    logic [2:0] cur_esc;
    logic [2:0] cur_reg;
    logic       is_load;
    logic       is_store_pop;
    logic       finish;

    // Pop only from idle with something at the head
    assign dequeue = (state == fpu_queue_pkg::SEQ_IDLE) && !queue_empty && !flush_queue;

    // One less than the total since done is registered
    assign lat_start = 3'(fpu_queue_pkg::BASE_LATENCY) + 3'(head_operand_size) - 3'd1;

    assign finish = (state == fpu_queue_pkg::SEQ_EXEC) && (lat_count == 3'd1) && !flush_queue;

    // Stack effect from the instruction code
    assign cur_esc      = cur_instr[7:5];
    assign cur_reg      = cur_instr[4:2];
    assign is_load      = (cur_memory && cur_reg == 3'd0) ||
                          (cur_esc == 3'd7 && (cur_reg == 3'd4 || cur_reg == 3'd5));
    assign is_store_pop = (cur_memory && cur_reg == 3'd3) ||
                          (cur_esc == 3'd7 && (cur_reg == 3'd6 || cur_reg == 3'd7));

    // ========================================
    // FSM, latency counter and TOP
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= fpu_queue_pkg::SEQ_IDLE;
            lat_count <= '0;
            done      <= 1'b0;
            stack_top <= '0;
        end else begin
            done <= 1'b0;
            if (flush_queue) begin
                // Abort, TOP keeps its value
                state <= fpu_queue_pkg::SEQ_IDLE;
            end else begin
                case (state)
                    fpu_queue_pkg::SEQ_IDLE: begin
                        if (dequeue) begin
                            state     <= fpu_queue_pkg::SEQ_EXEC;
                            lat_count <= lat_start;
                        end
                    end
                    default: begin
                        if (finish) begin
                            state <= fpu_queue_pkg::SEQ_IDLE;
                            done  <= 1'b1;
                            // Push moves TOP down, pop moves it up
                            if (is_load) begin
                                stack_top <= stack_top - 3'd1;
                            end else if (is_store_pop) begin
                                stack_top <= stack_top + 3'd1;
                            end
                        end else begin
                            lat_count <= lat_count - 3'd1;
                        end
                    end
                endcase
            end
        end
    end

    // Capture head on pop, report on completion
    always_ff @(posedge clk) begin
        if (dequeue) begin
            cur_instr  <= head_instruction;
            cur_index  <= head_stack_index;
            cur_memory <= head_has_memory_op;
            cur_data   <= head_data;
        end
        if (finish) begin
            done_instruction <= cur_instr;
            // TOP before this instruction's own effect, wraps mod 8
            done_phys_reg    <= stack_top + cur_index;
            done_data        <= cur_data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fpu_queue_top.sv ====
// ========================================
// FPU instruction queue path
// ========================================
`timescale 1ns/1ps
`default_nettype none

module fpu_queue_top #(
    parameter int QUEUE_DEPTH = fpu_queue_pkg::DEFAULT_QUEUE_DEPTH
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          cmd_strobe,
    input  logic [2:0]                    cmd_esc,
    input  logic [7:0]                    cmd_modrm,
    input  fpu_queue_pkg::fpu_data_t      cmd_data,
    input  logic                          flush_queue,
    output logic                          done,
    output fpu_queue_pkg::instr_code_t    done_instruction,
    output fpu_queue_pkg::stack_index_t   done_phys_reg,
    output fpu_queue_pkg::fpu_data_t      done_data,
    output fpu_queue_pkg::stack_index_t   stack_top,
    output fpu_queue_pkg::queue_count_t   queue_count,
    output logic                          queue_full,
    output logic                          queue_empty,
    output logic                          overflow
);

    // Decoder to queue
    logic                          enqueue;
    fpu_queue_pkg::instr_code_t    dec_instruction;
    fpu_queue_pkg::stack_index_t   dec_stack_index;
    logic                          dec_has_memory_op;
    fpu_queue_pkg::operand_size_t  dec_operand_size;
    logic                          dec_is_integer;
    logic                          dec_is_bcd;
    fpu_queue_pkg::fpu_data_t      dec_data;

    // Queue head to sequencer
    logic                          dequeue;
    fpu_queue_pkg::instr_code_t    head_instruction;
    fpu_queue_pkg::stack_index_t   head_stack_index;
    logic                          head_has_memory_op;
    fpu_queue_pkg::operand_size_t  head_operand_size;
    fpu_queue_pkg::fpu_data_t      head_data;

    fpu_instr_decoder u_decoder (
        .clk               (clk),
        .reset             (reset),
        .cmd_strobe        (cmd_strobe),
        .cmd_esc           (cmd_esc),
        .cmd_modrm         (cmd_modrm),
        .cmd_data          (cmd_data),
        .enqueue           (enqueue),
        .instruction_out   (dec_instruction),
        .stack_index_out   (dec_stack_index),
        .has_memory_op_out (dec_has_memory_op),
        .operand_size_out  (dec_operand_size),
        .is_integer_out    (dec_is_integer),
        .is_bcd_out        (dec_is_bcd),
        .data_out          (dec_data)
    );

    // Integer and BCD flags are held for the arithmetic datapath, not the sequencer
    fpu_instruction_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk               (clk),
        .reset             (reset),
        .enqueue           (enqueue),
        .instruction_in    (dec_instruction),
        .stack_index_in    (dec_stack_index),
        .has_memory_op_in  (dec_has_memory_op),
        .operand_size_in   (dec_operand_size),
        .is_integer_in     (dec_is_integer),
        .is_bcd_in         (dec_is_bcd),
        .data_in           (dec_data),
        .dequeue           (dequeue),
        .flush_queue       (flush_queue),
        .instruction_out   (head_instruction),
        .stack_index_out   (head_stack_index),
        .has_memory_op_out (head_has_memory_op),
        .operand_size_out  (head_operand_size),
        .is_integer_out    (),
        .is_bcd_out        (),
        .data_out          (head_data),
        .queue_full        (queue_full),
        .queue_empty       (queue_empty),
        .queue_count       (queue_count),
        .overflow          (overflow)
    );

    fpu_exec_sequencer u_sequencer (
        .clk                (clk),
        .reset              (reset),
        .flush_queue        (flush_queue),
        .queue_empty        (queue_empty),
        .head_instruction   (head_instruction),
        .head_stack_index   (head_stack_index),
        .head_has_memory_op (head_has_memory_op),
        .head_operand_size  (head_operand_size),
        .head_data          (head_data),
        .dequeue            (dequeue),
        .done               (done),
        .done_instruction   (done_instruction),
        .done_phys_reg      (done_phys_reg),
        .done_data          (done_data),
        .stack_top          (stack_top)
    );

endmodule

`default_nettype wire

// ==== verification/tb_fpu_queue_top.sv ====
// ========================================
// FPU queue path testbench
// ========================================
`timescale 1ns/1ps
`default_nettype none

module tb_fpu_queue_top;

    localparam int DEPTH   = fpu_queue_pkg::DEFAULT_QUEUE_DEPTH;
    localparam int TIMEOUT = 200;

    logic                          clk;
    logic                          reset;
    logic                          cmd_strobe;
    logic [2:0]                    cmd_esc;
    logic [7:0]                    cmd_modrm;
    fpu_queue_pkg::fpu_data_t      cmd_data;
    logic                          flush_queue;
    logic                          done;
    fpu_queue_pkg::instr_code_t    done_instruction;
    fpu_queue_pkg::stack_index_t   done_phys_reg;
    fpu_queue_pkg::fpu_data_t      done_data;
    fpu_queue_pkg::stack_index_t   stack_top;
    fpu_queue_pkg::queue_count_t   queue_count;
    logic                          queue_full;
    logic                          queue_empty;
    logic                          overflow;

    // ========================================
    // Reference model state
    // ========================================
    // Entry layout instr [93:86], index [85:83], memory [82], size [81:80], data [79:0]
    logic [93:0] model_q[$];
    logic        model_enq;
    logic [93:0] model_enq_entry;
    logic        model_busy;
    int          model_done_at;
    logic [93:0] model_cur;
    logic [2:0]  model_top;
    logic        exp_overflow;
    logic        exp_done;
    logic [93:0] exp_entry;
    logic [2:0]  exp_phys_reg;
    int          cycle_count;
    logic [15:0] lfsr;

    fpu_queue_top UUT (
        .clk              (clk),
        .reset            (reset),
        .cmd_strobe       (cmd_strobe),
        .cmd_esc          (cmd_esc),
        .cmd_modrm        (cmd_modrm),
        .cmd_data         (cmd_data),
        .flush_queue      (flush_queue),
        .done             (done),
        .done_instruction (done_instruction),
        .done_phys_reg    (done_phys_reg),
        .done_data        (done_data),
        .stack_top        (stack_top),
        .queue_count      (queue_count),
        .queue_full       (queue_full),
        .queue_empty      (queue_empty),
        .overflow         (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Count of rising edges since time zero
    initial cycle_count = 0;
    always @(posedge clk) cycle_count = cycle_count + 1;

    // ========================================
    // Helpers
    // ========================================
    task automatic check_value(input string name, input logic [79:0] actual,
                               input logic [79:0] expected);
        assert (actual === expected) else begin
            $display("FAIL %s actual 0x%0h expected 0x%0h", name, actual, expected);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        $display("TB FAILED");
        $fatal(1);
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int count, output logic [79:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[78:0], lfsr[0]};
        end
    endtask

    // Escape and ModR/M to queue fields
    function automatic logic [93:0] decode_command(input logic [2:0] esc,
                                                   input logic [7:0] modrm,
                                                   input logic [79:0] data);
        logic [1:0] mod_f;
        logic [2:0] reg_f;
        logic       memory;
        logic [1:0] size;
        mod_f  = modrm[7:6];
        reg_f  = modrm[5:3];
        memory = (mod_f != 2'd3);
        if (!memory) begin
            size = 2'd3;
        end else if (esc == 3'd7 && (reg_f == 3'd4 || reg_f == 3'd6)) begin
            // Packed BCD
            size = 2'd3;
        end else begin
            case (esc)
                3'd0, 3'd1, 3'd2, 3'd3: size = 2'd1;
                3'd4, 3'd5:             size = 2'd2;
                default:                size = 2'd0;
            endcase
        end
        return {esc, reg_f, mod_f, (memory ? 3'd0 : modrm[2:0]), memory, size, data};
    endfunction

    // Loads push (TOP down), store-and-pop moves TOP up
    function automatic logic [2:0] next_top(input logic [93:0] entry, input logic [2:0] top);
        logic [2:0] esc;
        logic [2:0] reg_f;
        logic       memory;
        esc    = entry[93:91];
        reg_f  = entry[90:88];
        memory = entry[82];
        if ((memory && reg_f == 3'd0) || (esc == 3'd7 && (reg_f == 3'd4 || reg_f == 3'd5)))
            return top - 3'd1;
        if ((memory && reg_f == 3'd3) || (esc == 3'd7 && (reg_f == 3'd6 || reg_f == 3'd7)))
            return top + 3'd1;
        return top;
    endfunction

    task automatic reset_model();
        model_q.delete();
        model_enq     = 1'b0;
        model_busy    = 1'b0;
        model_done_at = 0;
        model_top     = 3'd0;
        exp_overflow  = 1'b0;
        exp_done      = 1'b0;
    endtask

    task automatic compare_outputs();
        check_value("queue_count", 80'(queue_count), 80'(model_q.size()));
        check_value("queue_full", 80'(queue_full), 80'(model_q.size() == DEPTH));
        check_value("queue_empty", 80'(queue_empty), 80'(model_q.size() == 0));
        check_value("overflow", 80'(overflow), 80'(exp_overflow));
        check_value("done", 80'(done), 80'(exp_done));
        check_value("stack_top", 80'(stack_top), 80'(model_top));
        if (exp_done) begin
            check_value("done_instruction", 80'(done_instruction), 80'(exp_entry[93:86]));
            check_value("done_phys_reg", 80'(done_phys_reg), 80'(exp_phys_reg));
            check_value("done_data", done_data, exp_entry[79:0]);
        end
    endtask

    // Step the model over the next rising edge with this cycle's inputs
    task automatic advance_model();
        logic deq;
        logic push;
        deq  = !model_busy && model_q.size() > 0 && !flush_queue;
        push = model_enq && model_q.size() < DEPTH;
        exp_overflow = model_enq && model_q.size() == DEPTH && !flush_queue;
        exp_done     = 1'b0;
        if (flush_queue) begin
            // Entry in execution is aborted
            model_busy = 1'b0;
        end else if (model_busy && cycle_count + 1 == model_done_at) begin
            exp_done     = 1'b1;
            exp_entry    = model_cur;
            exp_phys_reg = model_top + model_cur[85:83];
            model_top    = next_top(model_cur, model_top);
            model_busy   = 1'b0;
        end
        if (flush_queue) begin
            model_q.delete();
        end else begin
            if (deq) begin
                model_cur     = model_q.pop_front();
                model_busy    = 1'b1;
                model_done_at = cycle_count + fpu_queue_pkg::BASE_LATENCY
                                + int'(model_cur[81:80]);
            end
            if (push) begin
                model_q.push_back(model_enq_entry);
            end
        end
        // Decoder stage
        model_enq = cmd_strobe;
        if (cmd_strobe) begin
            model_enq_entry = decode_command(cmd_esc, cmd_modrm, cmd_data);
        end
    endtask

    // Checks and model step at the falling edge
    always @(negedge clk) begin
        if (reset) begin
            reset_model();
        end else begin
            compare_outputs();
            advance_model();
        end
    end

    // ========================================
    // Stimulus
    // ========================================
    task automatic drive_cycle(input logic strobe, input logic [2:0] esc,
                               input logic [7:0] modrm, input logic [79:0] data,
                               input logic flush);
        @(posedge clk);
        #1;
        cmd_strobe  = strobe;
        cmd_esc     = esc;
        cmd_modrm   = modrm;
        cmd_data    = data;
        flush_queue = flush;
    endtask

    task automatic send_random(input logic flush);
        logic [79:0] esc_bits;
        logic [79:0] modrm_bits;
        logic [79:0] data_bits;
        take_bits(3, esc_bits);
        take_bits(8, modrm_bits);
        take_bits(80, data_bits);
        drive_cycle(1'b1, esc_bits[2:0], modrm_bits[7:0], data_bits, flush);
    endtask

    task automatic wait_until_idle();
        int waited;
        waited = 0;
        drive_cycle(1'b0, 3'd0, 8'd0, '0, 1'b0);
        while (model_busy || model_enq || model_q.size() != 0) begin
            if (waited == TIMEOUT) report_timeout("the queue path to drain");
            drive_cycle(1'b0, 3'd0, 8'd0, '0, 1'b0);
            waited++;
        end
    endtask

    // Single command into an idle, empty path
    task automatic measure_latency(input logic [2:0] esc, input logic [7:0] modrm);
        logic [79:0] data_bits;
        logic [93:0] entry;
        logic [1:0]  size;
        int          start;
        int          waited;
        take_bits(80, data_bits);
        entry = decode_command(esc, modrm, data_bits);
        size  = entry[81:80];
        wait_until_idle();
        drive_cycle(1'b1, esc, modrm, data_bits, 1'b0);
        start = cycle_count;
        drive_cycle(1'b0, 3'd0, 8'd0, '0, 1'b0);
        waited = 0;
        @(negedge clk);
        while (done !== 1'b1) begin
            if (waited == TIMEOUT) report_timeout("done after a single command");
            @(negedge clk);
            waited++;
        end
        check_value("latency", 80'(cycle_count - start), 80'(4 + int'(size)));
    endtask

    initial begin
        int          n;
        logic [79:0] gap;
        logic [79:0] flush_bits;
        lfsr        = 16'd18;
        cmd_strobe  = 1'b0;
        cmd_esc     = 3'd0;
        cmd_modrm   = 8'd0;
        cmd_data    = '0;
        flush_queue = 1'b0;
        reset       = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        // One command per operand size from 16 to 80 bits
        measure_latency(3'd6, 8'h10);
        measure_latency(3'd0, 8'h10);
        measure_latency(3'd4, 8'h10);
        measure_latency(3'd0, 8'hC1);

        // Burst faster than the drain fills the queue and overflows
        for (n = 0; n < 8; n++) send_random(1'b0);
        wait_until_idle();

        // Flush with one executing, one queued, one arriving
        for (n = 0; n < 3; n++) send_random(1'b0);
        drive_cycle(1'b0, 3'd0, 8'd0, '0, 1'b1);
        drive_cycle(1'b0, 3'd0, 8'd0, '0, 1'b0);
        @(negedge clk);
        check_value("queue_count", 80'(queue_count), 80'd0);

        // Random mix with gaps and occasional flush
        for (n = 0; n < 300; n++) begin
            take_bits(2, gap);
            take_bits(4, flush_bits);
            repeat (int'(gap[1:0])) drive_cycle(1'b0, 3'd0, 8'd0, '0, 1'b0);
            send_random(flush_bits[3:0] == 4'd0);
        end
        wait_until_idle();

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/fpu_queue_pkg.sv
verilog/fpu_instr_decoder.sv
verilog/fpu_instruction_queue.sv
verilog/fpu_exec_sequencer.sv
verilog/fpu_queue_top.sv
verification/tb_fpu_queue_top.sv

// ==== Makefile ====
# Verilator build and run for the FPU instruction queue path

VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_fpu_queue_top
FILELIST  := sim.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(OBJ_DIR)
